// File: filelist.f
logic/mem_stage_pkg.sv
logic/store_align.sv
logic/byte_lane_bank.sv
logic/load_extract.sv
logic/mem_stage.sv
verification/mem_stage_asserts.sv
verification/mem_stage_tb.sv

// File: Bender.yml
package:
  name: mem_stage

# RTL first, package at the head, then the testbench sources
sources:
  - logic/mem_stage_pkg.sv
  - logic/store_align.sv
  - logic/byte_lane_bank.sv
  - logic/load_extract.sv
  - logic/mem_stage.sv

  - target: test
    files:
      - verification/mem_stage_asserts.sv
      - verification/mem_stage_tb.sv

// File: verification/mem_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_tb;

  typedef struct packed {
    logic                     valid;
    mem_stage_pkg::mem_resp_t resp;
  } expect_t;

  typedef struct packed {
    mem_stage_pkg::mem_op_e            op;
    mem_stage_pkg::xword_t             addr;
    mem_stage_pkg::xword_t             data;
    logic [mem_stage_pkg::regno_w-1:0] rd_regno;
    logic                              update_rd;
    mem_stage_pkg::xword_t             exp_mdata;
    logic                              exp_out;  // also the in_enable of the entry
  } table_entry_t;

  logic                     clk;
  logic                     rst_n;
  logic                     flush;
  logic                     in_enable;
  mem_stage_pkg::mem_req_t  req;
  logic                     out_valid;
  mem_stage_pkg::mem_resp_t resp;

  expect_t                 exp_q[$];  // one slot per cycle, oldest first
  table_entry_t            stim_table[$];
  logic [7:0]              shadow [2**(mem_stage_pkg::word_index_w + mem_stage_pkg::offset_w)];
  mem_stage_pkg::mem_req_t pend_req;  // store still waiting for its write edge
  logic                    pend_valid;
  int                      seed;

  mem_stage uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .in_enable (in_enable),
    .req       (req),
    .out_valid (out_valid),
    .resp      (resp)
  );

  bind mem_stage mem_stage_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .in_enable (in_enable),
    .out_valid (out_valid),
    .lane_cmd  (lane_cmd),
    .sideband  (sideband)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp) begin
      report_error($sformatf("CHECK FAILED out_valid got %h expected %h", got, exp));
    end
  endtask

  task automatic check_resp(input mem_stage_pkg::mem_resp_t got,
                            input mem_stage_pkg::mem_resp_t exp);
    if (got.mdata !== exp.mdata) begin
      report_error($sformatf("CHECK FAILED resp.mdata got %h expected %h",
                             got.mdata, exp.mdata));
    end
    if (got.alu_result !== exp.alu_result) begin
      report_error($sformatf("CHECK FAILED resp.alu_result got %h expected %h",
                             got.alu_result, exp.alu_result));
    end
    if (got.rd_regno !== exp.rd_regno) begin
      report_error($sformatf("CHECK FAILED resp.rd_regno got %h expected %h",
                             got.rd_regno, exp.rd_regno));
    end
    if (got.update_rd !== exp.update_rd) begin
      report_error($sformatf("CHECK FAILED resp.update_rd got %h expected %h",
                             got.update_rd, exp.update_rd));
    end
  endtask

  function automatic int op_size(input mem_stage_pkg::mem_op_e op);
    case (op)
      mem_stage_pkg::op_lb, mem_stage_pkg::op_lbu, mem_stage_pkg::op_sb: return 1;
      mem_stage_pkg::op_lh, mem_stage_pkg::op_lhu, mem_stage_pkg::op_sh: return 2;
      mem_stage_pkg::op_lw, mem_stage_pkg::op_lwu, mem_stage_pkg::op_sw: return 4;
      mem_stage_pkg::op_ld, mem_stage_pkg::op_sd:                        return 8;
      default:                                                           return 0;
    endcase
  endfunction

  function automatic logic op_writes(input mem_stage_pkg::mem_op_e op);
    return op inside {mem_stage_pkg::op_sb, mem_stage_pkg::op_sh,
                      mem_stage_pkg::op_sw, mem_stage_pkg::op_sd};
  endfunction

  function automatic logic op_signed(input mem_stage_pkg::mem_op_e op);
    return op inside {mem_stage_pkg::op_lb, mem_stage_pkg::op_lh, mem_stage_pkg::op_lw};
  endfunction

  function automatic logic fits(input mem_stage_pkg::mem_op_e op,
                                input mem_stage_pkg::xword_t addr);
    int size;
    size = op_size(op);
    return (size != 0) && ((int'(addr[2:0]) % size) == 0);
  endfunction

  // word index and offset together, high address bits dropped
  function automatic int byte_slot(input mem_stage_pkg::xword_t addr);
    return int'(addr[mem_stage_pkg::word_index_w + mem_stage_pkg::offset_w - 1:0]);
  endfunction

  function automatic mem_stage_pkg::xword_t predict_load(input mem_stage_pkg::mem_op_e op,
                                                         input mem_stage_pkg::xword_t addr);
    mem_stage_pkg::xword_t value;
    int size;
    int base;
    value = '0;
    size  = op_size(op);
    base  = byte_slot(addr);
    if (op_writes(op) || !fits(op, addr)) begin
      return '0;  // stores, op_none and misaligned loads
    end
    for (int i = 0; i < size; i++) begin
      value[8*i +: 8] = shadow[base + i];
    end
    if (op_signed(op) && value[8*size-1]) begin
      for (int i = 8 * size; i < 64; i++) begin
        value[i] = 1'b1;
      end
    end
    return value;
  endfunction

  task automatic apply_store(input mem_stage_pkg::mem_req_t r);
    int base;
    base = byte_slot(r.alu_result);
    if (op_writes(r.op) && fits(r.op, r.alu_result)) begin
      for (int i = 0; i < op_size(r.op); i++) begin
        shadow[base + i] = r.rs2_value[8*i +: 8];
      end
    end
  endtask

  // check the slot issued three edges ago, then drive the next one
  task automatic drive_step(input logic en, input mem_stage_pkg::mem_req_t r,
                            input logic fl, input expect_t e);
    expect_t due;
    expect_t fresh;
    expect_t hold;
    @(posedge clk);
    #2;
    if (exp_q.size() == 3) begin
      due = exp_q.pop_front();
      check_valid(out_valid, due.valid);
      if (due.valid) begin
        check_resp(resp, due.resp);
      end
    end
    fresh       = e;
    fresh.valid = e.valid && en;
    if (fl) begin
      for (int i = 0; i < exp_q.size(); i++) begin  // their last edges see the flush
        hold       = exp_q[i];
        hold.valid = 1'b0;
        exp_q[i]   = hold;
      end
      fresh.valid = 1'b0;
    end
    in_enable = en;
    req       = r;
    flush     = fl;
    exp_q.push_back(fresh);
  endtask

  task automatic idle_step();
    mem_stage_pkg::mem_req_t r;
    expect_t e;
    if (pend_valid) begin
      apply_store(pend_req);
    end
    pend_valid = 1'b0;
    r = '0;
    e = '0;
    drive_step(1'b0, r, 1'b0, e);
  endtask

  task automatic model_issue(input mem_stage_pkg::mem_op_e op, input mem_stage_pkg::xword_t addr,
                             input mem_stage_pkg::xword_t data, input int rd,
                             input logic upd, input logic fl);
    mem_stage_pkg::mem_req_t r;
    expect_t e;
    // previous store writes on the edge that samples this flush
    if (pend_valid && !fl) begin
      apply_store(pend_req);
    end
    r.op                = op;
    r.alu_result        = addr;
    r.rs2_value         = data;
    r.rd_regno          = rd[mem_stage_pkg::regno_w-1:0];
    r.update_rd         = upd;
    e.valid             = 1'b1;
    e.resp.mdata        = predict_load(op, addr);
    e.resp.alu_result   = addr;
    e.resp.rd_regno     = r.rd_regno;
    e.resp.update_rd    = upd;
    pend_req            = r;
    pend_valid          = !fl;
    drive_step(1'b1, r, fl, e);
  endtask

  function automatic int outstanding();
    int n;
    n = 0;
    foreach (exp_q[i]) begin
      if (exp_q[i].valid) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic wait_outstanding();
    int guard;
    guard = 0;
    while (outstanding() != 0 && guard < 8) begin
      idle_step();
      guard++;
    end
    if (outstanding() != 0) begin
      report_error("timed out waiting for the pipeline to return its last responses");
    end
  endtask

  task automatic add_entry(input mem_stage_pkg::mem_op_e op, input mem_stage_pkg::xword_t addr,
                           input mem_stage_pkg::xword_t data, input int rd, input logic upd,
                           input mem_stage_pkg::xword_t mdata, input logic out);
    table_entry_t ent;
    ent.op        = op;
    ent.addr      = addr;
    ent.data      = data;
    ent.rd_regno  = rd[mem_stage_pkg::regno_w-1:0];
    ent.update_rd = upd;
    ent.exp_mdata = mdata;
    ent.exp_out   = out;
    stim_table.push_back(ent);
  endtask

  task automatic build_table();
    add_entry(mem_stage_pkg::op_none, 64'h0, 64'h0, 0, 1'b0, 64'h0, 1'b0);  // idle after reset
    add_entry(mem_stage_pkg::op_none, 64'h0, 64'h0, 0, 1'b0, 64'h0, 1'b0);
    add_entry(mem_stage_pkg::op_none, 64'h0, 64'h0, 0, 1'b0, 64'h0, 1'b0);
    add_entry(mem_stage_pkg::op_sd, 64'h100, 64'h0123456789abcdef, 1, 1'b0, 64'h0, 1'b1);
    add_entry(mem_stage_pkg::op_ld, 64'h100, 64'h0, 2, 1'b1, 64'h0123456789abcdef, 1'b1);
    add_entry(mem_stage_pkg::op_sd, 64'h108, 64'h1122334455667788, 3, 1'b0, 64'h0, 1'b1);
    add_entry(mem_stage_pkg::op_sb, 64'h10b, 64'hffffffffffffffa5, 4, 1'b0, 64'h0, 1'b1);
    add_entry(mem_stage_pkg::op_sh, 64'h10e, 64'h123400000000beef, 5, 1'b0, 64'h0, 1'b1);
    add_entry(mem_stage_pkg::op_ld, 64'h108, 64'h0, 6, 1'b1, 64'hbeef3344a5667788, 1'b1);
    add_entry(mem_stage_pkg::op_sw, 64'h108, 64'h55555555cafef00d, 7, 1'b0, 64'h0, 1'b1);
    add_entry(mem_stage_pkg::op_ld, 64'h108, 64'h0, 8, 1'b1, 64'hbeef3344cafef00d, 1'b1);
    add_entry(mem_stage_pkg::op_sd, 64'h118, 64'h0f1e2d3c4b5a6978, 9, 1'b0, 64'h0, 1'b1);
    add_entry(mem_stage_pkg::op_sh, 64'h119, 64'hffffffffffffffff, 10, 1'b0, 64'h0, 1'b1);
    add_entry(mem_stage_pkg::op_sw, 64'h11a, 64'hffffffffffffffff, 11, 1'b0, 64'h0, 1'b1);
    add_entry(mem_stage_pkg::op_sd, 64'h11c, 64'hffffffffffffffff, 12, 1'b0, 64'h0, 1'b1);
    add_entry(mem_stage_pkg::op_ld, 64'h118, 64'h0, 13, 1'b1, 64'h0f1e2d3c4b5a6978, 1'b1);
    add_entry(mem_stage_pkg::op_lh, 64'h119, 64'h0, 14, 1'b1, 64'h0, 1'b1);  // misaligned
    add_entry(mem_stage_pkg::op_lw, 64'h11a, 64'h0, 15, 1'b1, 64'h0, 1'b1);
    add_entry(mem_stage_pkg::op_ld, 64'h11c, 64'h0, 16, 1'b1, 64'h0, 1'b1);
    add_entry(mem_stage_pkg::op_lhu, 64'h11b, 64'h0, 17, 1'b1, 64'h0, 1'b1);
    add_entry(mem_stage_pkg::op_lbu, 64'h11f, 64'h0, 18, 1'b1, 64'h0f, 1'b1);
    add_entry(mem_stage_pkg::op_none, 64'hdeadbeef00001234, 64'h55, 31, 1'b1, 64'h0, 1'b1);
  endtask

  task automatic run_table();
    mem_stage_pkg::mem_req_t r;
    expect_t e;
    foreach (stim_table[i]) begin
      r.op              = stim_table[i].op;
      r.alu_result      = stim_table[i].addr;
      r.rs2_value       = stim_table[i].data;
      r.rd_regno        = stim_table[i].rd_regno;
      r.update_rd       = stim_table[i].update_rd;
      e.valid           = stim_table[i].exp_out;
      e.resp.mdata      = stim_table[i].exp_mdata;
      e.resp.alu_result = stim_table[i].addr;
      e.resp.rd_regno   = stim_table[i].rd_regno;
      e.resp.update_rd  = stim_table[i].update_rd;
      drive_step(stim_table[i].exp_out, r, 1'b0, e);
    end
  endtask

  // every load kind at every offset, on two words of opposite byte signs
  task automatic sweep_loads();
    mem_stage_pkg::mem_op_e load_ops [7];
    mem_stage_pkg::xword_t  words [2];
    mem_stage_pkg::xword_t  addr;
    load_ops = '{mem_stage_pkg::op_lb, mem_stage_pkg::op_lbu, mem_stage_pkg::op_lh,
                 mem_stage_pkg::op_lhu, mem_stage_pkg::op_lw, mem_stage_pkg::op_lwu,
                 mem_stage_pkg::op_ld};
    words[0] = 64'h81237f45f0e10c9a;
    words[1] = 64'h01a3ffc570618c12;
    for (int w = 0; w < 2; w++) begin
      addr = 64'h180 + 64'h8 * w;
      model_issue(mem_stage_pkg::op_sd, addr, words[w], w, 1'b0, 1'b0);
      for (int k = 0; k < 7; k++) begin
        for (int offs = 0; offs < 8; offs++) begin
          addr[2:0] = offs[2:0];
          model_issue(load_ops[k], addr, 64'h0, offs, 1'b1, 1'b0);
        end
      end
    end
  endtask

  task automatic random_stream();
    mem_stage_pkg::mem_op_e op;
    mem_stage_pkg::xword_t  addr;
    mem_stage_pkg::xword_t  data;
    int                     rnd;
    int                     pick;
    for (int w = 0; w < 16; w++) begin  // no load may see an unwritten byte
      addr      = '0;
      addr[6:3] = w[3:0];
      model_issue(mem_stage_pkg::op_sd, addr, {$random(seed), $random(seed)}, w, 1'b0, 1'b0);
    end
    for (int i = 0; i < 200; i++) begin
      rnd       = $random(seed);
      pick      = $unsigned(rnd) % 12;
      op        = mem_stage_pkg::mem_op_e'(pick[3:0]);
      addr      = {$random(seed), $random(seed)};
      addr[10:7] = 4'h0;  // words 0 to 15
      data      = {$random(seed), $random(seed)};
      if (i == 99) begin
        op        = mem_stage_pkg::op_sd;  // lands inside the flush window
        addr[6:0] = 7'h28;
      end
      if (i == 104) begin
        op        = mem_stage_pkg::op_ld;
        addr[6:0] = 7'h28;
      end
      model_issue(op, addr, data, rnd[12:8], rnd[20], (i == 100) || (i == 101));
    end
  endtask

  initial begin
    seed        = 32'h619f29a5;
    pend_valid  = 1'b0;
    pend_req    = '0;
    rst_n       = 1'b0;
    flush       = 1'b0;
    in_enable   = 1'b0;
    req         = '0;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_valid(out_valid, 1'b0);
    build_table();
    run_table();
    wait_outstanding();
    sweep_loads();
    wait_outstanding();
    random_stream();
    wait_outstanding();
    if (uut.u_asserts.assert_fails == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/mem_stage_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_asserts (
  input logic                                                     clk,
  input logic                                                     rst_n,
  input logic                                                     flush,
  input logic                                                     in_enable,
  input logic                                                     out_valid,
  input mem_stage_pkg::lane_cmd_t [mem_stage_pkg::lane_count-1:0] lane_cmd,
  input mem_stage_pkg::mem_sideband_t                             sideband
);

  logic [mem_stage_pkg::lane_count-1:0] we_bits;
  logic                                 store_op;
  int                                   assert_fails = 0;  // read by the testbench at the end

  always_comb begin
    for (int k = 0; k < mem_stage_pkg::lane_count; k++) begin
      we_bits[k] = lane_cmd[k].we;
    end
  end

  assign store_op = sideband.op inside {mem_stage_pkg::op_sb, mem_stage_pkg::op_sh,
                                        mem_stage_pkg::op_sw, mem_stage_pkg::op_sd};

  reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
    else begin
      $error("out_valid high while in reset");
      assert_fails++;
    end

  // accepted and not flushed on any of its edges
  three_edge_latency: assert property (@(posedge clk) disable iff (!rst_n)
    (in_enable && !flush) ##1 !flush ##1 !flush |=> out_valid)
    else begin
      $error("out_valid missing three edges after an accepted request");
      assert_fails++;
    end

  flush_blocks_writes: assert property (@(posedge clk) disable iff (!rst_n)
    flush |-> (we_bits == '0))
    else begin
      $error("lane write enabled during flush");
      assert_fails++;
    end

  stores_only_write: assert property (@(posedge clk) disable iff (!rst_n)
    !store_op |-> (we_bits == '0))
    else begin
      $error("lane write enabled for a non-store op");
      assert_fails++;
    end

endmodule

`default_nettype wire

// File: logic/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush,
  input  logic                     in_enable,
  input  mem_stage_pkg::mem_req_t  req,
  output logic                     out_valid,
  output mem_stage_pkg::mem_resp_t resp
);

  logic                                   s1_valid;
  logic [mem_stage_pkg::word_index_w-1:0] word_index;
  mem_stage_pkg::lane_cmd_t [mem_stage_pkg::lane_count-1:0] lane_cmd;
  mem_stage_pkg::mem_sideband_t           sideband;
  logic [mem_stage_pkg::lane_count-1:0][mem_stage_pkg::byte_w-1:0] lane_data;

  store_align u_store_align (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .in_enable  (in_enable),
    .req        (req),
    .s1_valid   (s1_valid),
    .word_index (word_index),
    .lane_cmd   (lane_cmd),
    .sideband   (sideband)
  );

  // one bank per byte lane, all at the same word
  for (genvar k = 0; k < mem_stage_pkg::lane_count; k++) begin : g_lane
    byte_lane_bank u_bank (
      .clk        (clk),
      .word_index (word_index),
      .cmd        (lane_cmd[k]),
      .rdata      (lane_data[k])
    );
  end

  load_extract u_load_extract (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .s1_valid  (s1_valid),
    .sideband  (sideband),
    .lane_data (lane_data),
    .out_valid (out_valid),
    .resp      (resp)
  );

endmodule

`default_nettype wire

// File: logic/load_extract.sv
`timescale 1ns/1ps
`default_nettype none

module load_extract (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  flush,
  input  logic                                  s1_valid,
  input  mem_stage_pkg::mem_sideband_t          sideband,
  input  logic [mem_stage_pkg::lane_count-1:0][mem_stage_pkg::byte_w-1:0] lane_data,
  output logic                                  out_valid,
  output mem_stage_pkg::mem_resp_t              resp
);

  logic                         s2_valid;
  mem_stage_pkg::mem_sideband_t sb_q;
  mem_stage_pkg::xword_t        line;
  mem_stage_pkg::xword_t        picked;
  mem_stage_pkg::xword_t        mdata;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s2_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s2_valid  <= s1_valid && !flush;
      out_valid <= s2_valid && !flush;
    end
  end

  // lines up with the bank read issued on the same edge
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      sb_q <= sideband;
    end
  end

  assign line   = lane_data;
  assign picked = line >> (sb_q.offset * mem_stage_pkg::byte_w);  // addressed byte to bit 0

  always_comb begin
    mdata = '0;
    if (mem_stage_pkg::is_load(sb_q.op) && mem_stage_pkg::is_aligned(sb_q.op, sb_q.offset)) begin
      case (sb_q.op)
        mem_stage_pkg::op_lb: begin
          mdata = mem_stage_pkg::xword_t'($signed(picked[mem_stage_pkg::byte_w-1:0]));
        end
        mem_stage_pkg::op_lbu: begin
          mdata = mem_stage_pkg::xword_t'(picked[mem_stage_pkg::byte_w-1:0]);
        end
        mem_stage_pkg::op_lh: begin
          mdata = mem_stage_pkg::xword_t'($signed(picked[2*mem_stage_pkg::byte_w-1:0]));
        end
        mem_stage_pkg::op_lhu: begin
          mdata = mem_stage_pkg::xword_t'(picked[2*mem_stage_pkg::byte_w-1:0]);
        end
        mem_stage_pkg::op_lw: begin
          mdata = mem_stage_pkg::xword_t'($signed(picked[4*mem_stage_pkg::byte_w-1:0]));
        end
        mem_stage_pkg::op_lwu: begin
          mdata = mem_stage_pkg::xword_t'(picked[4*mem_stage_pkg::byte_w-1:0]);
        end
        mem_stage_pkg::op_ld: begin
          mdata = picked;
        end
        default: begin
          mdata = '0;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (s2_valid) begin
      resp.mdata      <= mdata;
      resp.alu_result <= sb_q.alu_result;  // forwarded for write-back
      resp.rd_regno   <= sb_q.rd_regno;
      resp.update_rd  <= sb_q.update_rd;
    end
  end

endmodule

`default_nettype wire

// File: logic/byte_lane_bank.sv
`timescale 1ns/1ps
`default_nettype none

module byte_lane_bank (
  input  logic                                   clk,
  input  logic [mem_stage_pkg::word_index_w-1:0] word_index,
  input  mem_stage_pkg::lane_cmd_t               cmd,
  output logic [mem_stage_pkg::byte_w-1:0]       rdata
);

  logic [mem_stage_pkg::byte_w-1:0] mem [2**mem_stage_pkg::word_index_w];

  // read sees the old byte when the same word is written
  always_ff @(posedge clk) begin
    rdata <= mem[word_index];
    if (cmd.we) begin
      mem[word_index] <= cmd.wdata;
    end
  end

endmodule

`default_nettype wire

// File: logic/store_align.sv
`timescale 1ns/1ps
`default_nettype none

module store_align (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   flush,
  input  logic                                   in_enable,
  input  mem_stage_pkg::mem_req_t                req,
  output logic                                   s1_valid,
  output logic [mem_stage_pkg::word_index_w-1:0] word_index,
  output mem_stage_pkg::lane_cmd_t [mem_stage_pkg::lane_count-1:0] lane_cmd,
  output mem_stage_pkg::mem_sideband_t           sideband
);

  mem_stage_pkg::mem_req_t              req_q;
  logic [mem_stage_pkg::offset_w-1:0]   offset;
  mem_stage_pkg::access_bytes_t         nbytes;
  logic                                 store_ok;
  logic [mem_stage_pkg::lane_count-1:0] we_mask;
  mem_stage_pkg::xword_t                wdata_shifted;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_enable && !flush;
    end
  end

  always_ff @(posedge clk) begin
    if (in_enable) begin
      req_q <= req;
    end
  end

  assign offset     = req_q.alu_result[mem_stage_pkg::offset_w-1:0];
  assign word_index = req_q.alu_result[mem_stage_pkg::offset_w +: mem_stage_pkg::word_index_w];
  assign nbytes     = mem_stage_pkg::access_bytes(req_q.op);

  // misaligned stores and flushed slots write nothing
  assign store_ok = s1_valid && !flush
                    && mem_stage_pkg::is_store(req_q.op)
                    && mem_stage_pkg::is_aligned(req_q.op, offset);

  always_comb begin
    we_mask = '0;
    for (int k = 0; k < mem_stage_pkg::lane_count; k++) begin
      if (store_ok && (k >= offset) && (k < offset + nbytes)) begin
        we_mask[k] = 1'b1;
      end
    end
  end

  // byte 0 of the store data lands on the lane at the offset
  assign wdata_shifted = req_q.rs2_value << (offset * mem_stage_pkg::byte_w);

  always_comb begin
    for (int k = 0; k < mem_stage_pkg::lane_count; k++) begin
      lane_cmd[k].we    = we_mask[k];
      lane_cmd[k].wdata = wdata_shifted[k*mem_stage_pkg::byte_w +: mem_stage_pkg::byte_w];
    end
  end

  assign sideband.op         = req_q.op;
  assign sideband.offset     = offset;
  assign sideband.alu_result = req_q.alu_result;
  assign sideband.rd_regno   = req_q.rd_regno;
  assign sideband.update_rd  = req_q.update_rd;

endmodule

`default_nettype wire

// File: logic/mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

  localparam int xlen         = 64;
  localparam int lane_count   = 8;
  localparam int byte_w       = 8;
  localparam int offset_w     = 3;  // byte offset inside a doubleword
  localparam int word_index_w = 8;  // 256 doublewords per lane
  localparam int regno_w      = 5;

  typedef logic [xlen-1:0]   xword_t;
  typedef logic [offset_w:0] access_bytes_t;  // 1, 2, 4 or 8, zero for no access

  typedef enum logic [3:0] {
    op_none,
    op_lb,
    op_lbu,
    op_lh,
    op_lhu,
    op_lw,
    op_lwu,
    op_ld,
    op_sb,
    op_sh,
    op_sw,
    op_sd
  } mem_op_e;

  typedef struct packed {
    mem_op_e              op;
    xword_t               alu_result;  // address for loads and stores
    xword_t               rs2_value;
    logic [regno_w-1:0]   rd_regno;
    logic                 update_rd;
  } mem_req_t;

  typedef struct packed {
    logic              we;
    logic [byte_w-1:0] wdata;
  } lane_cmd_t;

  typedef struct packed {
    mem_op_e              op;
    logic [offset_w-1:0]  offset;
    xword_t               alu_result;
    logic [regno_w-1:0]   rd_regno;
    logic                 update_rd;
  } mem_sideband_t;

  typedef struct packed {
    xword_t               mdata;
    xword_t               alu_result;
    logic [regno_w-1:0]   rd_regno;
    logic                 update_rd;
  } mem_resp_t;

  function automatic logic is_load(mem_op_e op);
    return op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld};
  endfunction

  function automatic logic is_store(mem_op_e op);
    return op inside {op_sb, op_sh, op_sw, op_sd};
  endfunction

  function automatic access_bytes_t access_bytes(mem_op_e op);
    case (op)
      op_lb, op_lbu, op_sb: return access_bytes_t'(1);
      op_lh, op_lhu, op_sh: return access_bytes_t'(2);
      op_lw, op_lwu, op_sw: return access_bytes_t'(4);
      op_ld, op_sd:         return access_bytes_t'(8);
      default:              return access_bytes_t'(0);
    endcase
  endfunction

  // natural alignment by access size
  function automatic logic is_aligned(mem_op_e op, logic [offset_w-1:0] offset);
    access_bytes_t nbytes;
    logic [offset_w-1:0] low_mask;
    nbytes   = access_bytes(op);
    low_mask = nbytes[offset_w-1:0] - 1'b1;  // wraps to all ones for a doubleword
    return (nbytes != '0) && ((offset & low_mask) == '0);
  endfunction

endpackage

`default_nettype wire
